// ==== include/dcache_params.svh ====
// data cache geometry and memory bus widths
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// processor and bus widths
`define DC_ADDR_W     32
`define DC_WORD_W     32
`define DC_STRB_W     4

// 64 lines of 16 words, direct mapped
`define DC_INDEX_W    6
`define DC_OFFSET_W   4
`define DC_TAG_W      20
`define DC_LINE_WORDS 16

`endif

// ==== verilog/dcache_pkg.sv ====
// data cache shared types and controller state encoding
`default_nettype none

`include "dcache_params.svh"

package dcache_pkg;

    typedef logic [`DC_ADDR_W-1:0]   addr_t;
    typedef logic [`DC_WORD_W-1:0]   word_t;
    typedef logic [`DC_STRB_W-1:0]   strb_t;
    typedef logic [`DC_TAG_W-1:0]    tag_t;
    typedef logic [`DC_INDEX_W-1:0]  index_t;
    // word in line, doubles as burst beat number
    typedef logic [`DC_OFFSET_W-1:0] offset_t;
    typedef logic [`DC_LINE_WORDS*`DC_WORD_W-1:0] line_t;

    typedef enum logic [3:0] {
        IDLE,
        HIT_DONE,
        WB_ADDR,
        WB_DATA,
        WB_RESP,
        RF_ADDR,
        RF_DATA,
        FILL,
        DONE
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== verilog/dcache_store.sv ====
// data cache storage: tag, valid, dirty and line arrays, async read
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module dcache_store import dcache_pkg::*; (
    input  wire          clk,
    input  wire          resetn,
    input  wire index_t  index,
    input  wire          wr_en,
    input  wire tag_t    wr_tag,
    input  wire line_t   wr_line,
    input  wire          wr_dirty,
    output tag_t         rd_tag,
    output logic         rd_valid,
    output logic         rd_dirty,
    output line_t        rd_line
);

    localparam int LINES = 1 << `DC_INDEX_W;

    tag_t              tag_mem  [LINES];
    line_t             line_mem [LINES];
    logic [LINES-1:0]  valid_q;
    logic [LINES-1:0]  dirty_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (wr_en) begin
            valid_q[index] <= 1'b1;
            dirty_q[index] <= wr_dirty;
        end
    end

    // payload arrays
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[index]  <= wr_tag;
            line_mem[index] <= wr_line;
        end
    end

    assign rd_tag   = tag_mem[index];
    assign rd_line  = line_mem[index];
    assign rd_valid = valid_q[index];
    assign rd_dirty = dirty_q[index];

    // controller must stay quiet while reset clears the valid bits
    a_no_write_in_reset: assert property (@(posedge clk) !resetn |-> !wr_en);

endmodule

`default_nettype wire

// ==== verilog/dcache_lookup.sv ====
// address decode, tag compare and victim write-back decision
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module dcache_lookup import dcache_pkg::*; (
    input  wire addr_t   d_addr,
    input  wire tag_t    rd_tag,
    input  wire          rd_valid,
    input  wire          rd_dirty,
    output index_t       index,
    output offset_t      offset,
    output tag_t         tag,
    output logic         hit,
    output logic         writeback_needed,
    output addr_t        line_addr,
    output addr_t        victim_addr
);

    // byte bits below the word offset, then word offset, index and tag
    localparam int LINE_LSB  = `DC_OFFSET_W + 2;
    localparam int INDEX_MSB = LINE_LSB + `DC_INDEX_W - 1;

    assign offset = d_addr[LINE_LSB-1:2];
    assign index  = d_addr[INDEX_MSB:LINE_LSB];
    assign tag    = d_addr[`DC_ADDR_W-1:`DC_ADDR_W-`DC_TAG_W];

    assign hit = rd_valid && (rd_tag == tag);

    // dirty line of another tag must go out first
    assign writeback_needed = rd_valid && rd_dirty && !hit;

    assign line_addr   = {d_addr[`DC_ADDR_W-1:LINE_LSB], {LINE_LSB{1'b0}}};
    assign victim_addr = {rd_tag, index, {LINE_LSB{1'b0}}};

endmodule

`default_nettype wire

// ==== verilog/dcache_ctrl.sv ====
// cache controller sequencing hit, write-back and refill over the burst bus
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module dcache_ctrl import dcache_pkg::*; (
    input  wire          clk,
    input  wire          resetn,
    input  wire          d_req,
    input  wire          d_we,
    input  wire          hit,
    input  wire          writeback_needed,
    input  wire addr_t   line_addr,
    input  wire addr_t   victim_addr,
    input  wire          arready,
    input  wire          rvalid,
    input  wire          rlast,
    input  wire          awready,
    input  wire          wready,
    input  wire          bvalid,
    output addr_t        araddr,
    output logic         arvalid,
    output addr_t        awaddr,
    output logic         awvalid,
    output logic         wvalid,
    output logic         wlast,
    output logic         d_stall,
    output logic         store_wr_en,
    output logic         store_dirty,
    output logic         capture,
    output logic         beat_load,
    output offset_t      beat
);

    localparam offset_t LAST_BEAT = offset_t'(`DC_LINE_WORDS - 1);

    ctrl_state_t state;
    offset_t     beat_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state  <= IDLE;
            beat_q <= '0;
        end else begin
            case (state)
                IDLE: begin
                    beat_q <= '0;
                    if (d_req) begin
                        if (hit)
                            state <= HIT_DONE;
                        else if (writeback_needed)
                            state <= WB_ADDR;
                        else
                            state <= RF_ADDR;
                    end
                end
                HIT_DONE: state <= IDLE;
                WB_ADDR: begin
                    if (awready)
                        state <= WB_DATA;
                end
                WB_DATA: begin
                    // counter wraps back to 0 for the refill
                    if (wready) begin
                        beat_q <= beat_q + 1'b1;
                        if (beat_q == LAST_BEAT)
                            state <= WB_RESP;
                    end
                end
                WB_RESP: begin
                    if (bvalid)
                        state <= RF_ADDR;
                end
                RF_ADDR: begin
                    if (arready)
                        state <= RF_DATA;
                end
                RF_DATA: begin
                    if (rvalid) begin
                        beat_q <= beat_q + 1'b1;
                        if (rlast)
                            state <= FILL;
                    end
                end
                FILL: state <= DONE;
                DONE: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // address sources are held stable by the processor
    assign arvalid = (state == RF_ADDR);
    assign araddr  = line_addr;
    assign awvalid = (state == WB_ADDR);
    assign awaddr  = victim_addr;
    assign wvalid  = (state == WB_DATA);
    assign wlast   = wvalid && (beat_q == LAST_BEAT);

    // request completes in HIT_DONE or DONE
    assign d_stall = d_req && (state != HIT_DONE) && (state != DONE);

    assign store_wr_en = ((state == HIT_DONE) && d_we) || (state == FILL);
    assign store_dirty = d_we;
    assign capture     = (state == IDLE) && d_req && hit;
    assign beat_load   = (state == RF_DATA) && rvalid;
    assign beat        = beat_q;

    a_arvalid_hold: assert property (@(posedge clk) disable iff (!resetn)
        arvalid && !arready |=> arvalid && $stable(araddr));

    // write burst goes on after every beat but the one flagged last
    a_wlast_beat: assert property (@(posedge clk) disable iff (!resetn)
        wvalid && wready |=> wvalid != $past(wlast));

endmodule

`default_nettype wire

// ==== verilog/dcache_line_buf.sv ====
// line assembly for store merge and refill, read and write-back word select
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module dcache_line_buf import dcache_pkg::*; (
    input  wire          clk,
    input  wire          resetn,
    input  wire          capture,
    input  wire          beat_load,
    input  wire offset_t beat,
    input  wire offset_t offset,
    input  wire          d_we,
    input  wire word_t   d_wdata,
    input  wire strb_t   d_wstrb,
    input  wire line_t   rd_line,
    input  wire word_t   rdata,
    output line_t        wr_line,
    output word_t        wdata,
    output word_t        d_rdata
);

    line_t buf_q;

    // byte-strobe merge of a store into one word
    function automatic word_t merge_word(input word_t old_w, input word_t new_w,
                                         input strb_t strb);
        word_t res;
        res = old_w;
        for (int b = 0; b < `DC_STRB_W; b++) begin
            if (strb[b])
                res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

    always_ff @(posedge clk) begin
        if (capture) begin
            buf_q <= rd_line;
            if (d_we)
                buf_q[offset*`DC_WORD_W +: `DC_WORD_W] <=
                    merge_word(rd_line[offset*`DC_WORD_W +: `DC_WORD_W], d_wdata, d_wstrb);
        end else if (beat_load) begin
            if (d_we && (beat == offset))
                buf_q[beat*`DC_WORD_W +: `DC_WORD_W] <= merge_word(rdata, d_wdata, d_wstrb);
            else
                buf_q[beat*`DC_WORD_W +: `DC_WORD_W] <= rdata;
        end
    end

    assign wr_line = buf_q;
    assign d_rdata = buf_q[offset*`DC_WORD_W +: `DC_WORD_W];

    // victim words go out straight from the store
    assign wdata = rd_line[beat*`DC_WORD_W +: `DC_WORD_W];

    // store merge during refill needs a steady target word
    a_refill_req_stable: assert property (@(posedge clk) disable iff (!resetn)
        beat_load |-> $stable(offset) && $stable(d_we));

endmodule

`default_nettype wire

// ==== verilog/dcache_top.sv ====
// direct-mapped write-back data cache with burst memory port
`timescale 1ns/1ps
`default_nettype none

module dcache_top import dcache_pkg::*; (
    input  wire          clk,
    input  wire          resetn,
    // processor side
    input  wire          d_req,
    input  wire          d_we,
    input  wire addr_t   d_addr,
    input  wire word_t   d_wdata,
    input  wire strb_t   d_wstrb,
    output word_t        d_rdata,
    output logic         d_stall,
    // memory side
    output addr_t        araddr,
    output logic         arvalid,
    input  wire          arready,
    input  wire word_t   rdata,
    input  wire          rvalid,
    input  wire          rlast,
    output addr_t        awaddr,
    output logic         awvalid,
    input  wire          awready,
    output word_t        wdata,
    output logic         wvalid,
    input  wire          wready,
    output logic         wlast,
    input  wire          bvalid
);

    index_t  index;
    offset_t offset;
    tag_t    tag;
    tag_t    rd_tag;
    logic    rd_valid;
    logic    rd_dirty;
    line_t   rd_line;
    line_t   wr_line;
    logic    hit;
    logic    writeback_needed;
    addr_t   line_addr;
    addr_t   victim_addr;
    logic    store_wr_en;
    logic    store_dirty;
    logic    capture;
    logic    beat_load;
    offset_t beat;

    dcache_store i_dcache_store (
        .clk      (clk),
        .resetn   (resetn),
        .index    (index),
        .wr_en    (store_wr_en),
        .wr_tag   (tag),
        .wr_line  (wr_line),
        .wr_dirty (store_dirty),
        .rd_tag   (rd_tag),
        .rd_valid (rd_valid),
        .rd_dirty (rd_dirty),
        .rd_line  (rd_line)
    );

    dcache_lookup i_dcache_lookup (
        .d_addr           (d_addr),
        .rd_tag           (rd_tag),
        .rd_valid         (rd_valid),
        .rd_dirty         (rd_dirty),
        .index            (index),
        .offset           (offset),
        .tag              (tag),
        .hit              (hit),
        .writeback_needed (writeback_needed),
        .line_addr        (line_addr),
        .victim_addr      (victim_addr)
    );

    dcache_ctrl i_dcache_ctrl (
        .clk              (clk),
        .resetn           (resetn),
        .d_req            (d_req),
        .d_we             (d_we),
        .hit              (hit),
        .writeback_needed (writeback_needed),
        .line_addr        (line_addr),
        .victim_addr      (victim_addr),
        .arready          (arready),
        .rvalid           (rvalid),
        .rlast            (rlast),
        .awready          (awready),
        .wready           (wready),
        .bvalid           (bvalid),
        .araddr           (araddr),
        .arvalid          (arvalid),
        .awaddr           (awaddr),
        .awvalid          (awvalid),
        .wvalid           (wvalid),
        .wlast            (wlast),
        .d_stall          (d_stall),
        .store_wr_en      (store_wr_en),
        .store_dirty      (store_dirty),
        .capture          (capture),
        .beat_load        (beat_load),
        .beat             (beat)
    );

    dcache_line_buf i_dcache_line_buf (
        .clk       (clk),
        .resetn    (resetn),
        .capture   (capture),
        .beat_load (beat_load),
        .beat      (beat),
        .offset    (offset),
        .d_we      (d_we),
        .d_wdata   (d_wdata),
        .d_wstrb   (d_wstrb),
        .rd_line   (rd_line),
        .rdata     (rdata),
        .wr_line   (wr_line),
        .wdata     (wdata),
        .d_rdata   (d_rdata)
    );

endmodule

`default_nettype wire

// ==== test/tb_mem_model.sv ====
// burst memory model with pattern contents, write recording and random ready stalls
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module tb_mem_model import dcache_pkg::*; (
    input  wire         clk,
    input  wire         resetn,
    input  wire         stall_en,
    input  wire addr_t  araddr,
    input  wire         arvalid,
    output logic        arready,
    output word_t       rdata,
    output logic        rvalid,
    output logic        rlast,
    input  wire addr_t  awaddr,
    input  wire         awvalid,
    output logic        awready,
    input  wire word_t  wdata,
    input  wire         wvalid,
    output logic        wready,
    input  wire         wlast,
    output logic        bvalid
);

    localparam int      LINE_LSB  = `DC_OFFSET_W + 2;
    localparam offset_t LAST_BEAT = offset_t'(`DC_LINE_WORDS - 1);

    // written words only, the rest reads as the address pattern
    word_t       mem [addr_t];
    logic [31:0] rnd;
    logic        rd_active;
    addr_t       rd_addr;
    offset_t     rd_beat;
    addr_t       wr_addr;
    offset_t     wr_beat;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t read_word(input addr_t a);
        if (mem.exists(a))
            return mem[a];
        return a ^ 32'h5a5a_0000;
    endfunction

    always @(posedge clk) begin
        if (!resetn) begin
            rnd       <= 32'hc37e_e340;
            arready   <= 1'b0;
            awready   <= 1'b0;
            wready    <= 1'b0;
            rdata     <= '0;
            rvalid    <= 1'b0;
            rlast     <= 1'b0;
            bvalid    <= 1'b0;
            rd_active <= 1'b0;
            rd_beat   <= '0;
            wr_beat   <= '0;
        end else begin
            rnd     <= xorshift32(rnd);
            arready <= !stall_en || rnd[0];
            awready <= !stall_en || rnd[1];
            wready  <= !stall_en || rnd[2] || rnd[3];
            rvalid  <= 1'b0;
            rlast   <= 1'b0;
            // response one cycle after the last beat
            bvalid  <= wvalid && wready && wlast;
            if (rd_active) begin
                rvalid  <= 1'b1;
                rdata   <= read_word({rd_addr[`DC_ADDR_W-1:LINE_LSB], rd_beat, 2'b00});
                rlast   <= (rd_beat == LAST_BEAT);
                rd_beat <= rd_beat + 1'b1;
                if (rd_beat == LAST_BEAT)
                    rd_active <= 1'b0;
            end else if (arvalid && arready) begin
                rd_active <= 1'b1;
                rd_addr   <= araddr;
                rd_beat   <= '0;
            end
            if (awvalid && awready) begin
                wr_addr <= awaddr;
                wr_beat <= '0;
            end
            if (wvalid && wready) begin
                mem[{wr_addr[`DC_ADDR_W-1:LINE_LSB], wr_beat, 2'b00}] = wdata;
                wr_beat <= wr_beat + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_dcache.sv ====
// directed read, write, miss and eviction tests for the data cache
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module tb_dcache import dcache_pkg::*; ();

    // 10 bursts over both passes and each stays far below 200 cycles with stalls
    localparam int    MAX_CYCLES = 4000;
    localparam word_t HIT_DATA   = 32'hdead_beef;
    localparam strb_t HIT_STRB   = 4'b0101;
    localparam word_t MISS_DATA  = 32'h1234_5678;
    localparam strb_t MISS_STRB  = 4'b1100;

    logic  clk;
    logic  resetn;
    logic  stall_en;
    logic  d_req;
    logic  d_we;
    addr_t d_addr;
    word_t d_wdata;
    strb_t d_wstrb;
    word_t d_rdata;
    logic  d_stall;
    addr_t araddr;
    addr_t awaddr;
    word_t rdata;
    word_t wdata;
    logic  arvalid, arready, rvalid, rlast;
    logic  awvalid, awready, wvalid, wready, wlast, bvalid;

    int    cycles = 0;
    int    ar_count = 0;
    int    aw_count = 0;
    int    w_beats = 0;
    int    arvalid_cycles = 0;
    addr_t last_araddr;
    addr_t last_awaddr;

    dcache_top i_dcache_top (
        .clk(clk), .resetn(resetn),
        .d_req(d_req), .d_we(d_we), .d_addr(d_addr), .d_wdata(d_wdata),
        .d_wstrb(d_wstrb), .d_rdata(d_rdata), .d_stall(d_stall),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rvalid(rvalid), .rlast(rlast),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready), .wlast(wlast), .bvalid(bvalid)
    );

    tb_mem_model i_mem_model (
        .clk(clk), .resetn(resetn), .stall_en(stall_en),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rvalid(rvalid), .rlast(rlast),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready), .wlast(wlast), .bvalid(bvalid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // bus monitor sampling mid-cycle where the bus is settled
    always @(negedge clk) begin
        if (arvalid)
            arvalid_cycles <= arvalid_cycles + 1;
        if (arvalid && arready) begin
            ar_count    <= ar_count + 1;
            last_araddr <= araddr;
        end
        if (awvalid && awready) begin
            aw_count    <= aw_count + 1;
            last_awaddr <= awaddr;
        end
        if (wvalid && wready) begin
            if (wlast !== ((w_beats % `DC_LINE_WORDS) == `DC_LINE_WORDS - 1))
                abort_run($sformatf("Error at %0t: wlast was %b on write beat %0d",
                                    $time, wlast, w_beats % `DC_LINE_WORDS));
            w_beats <= w_beats + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
            abort_run($sformatf("timeout, run still busy after %0d cycles", MAX_CYCLES));
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp)
            abort_run($sformatf("Error at %0t: %s gave %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_addr(input string what, input addr_t got, input addr_t exp);
        if (got !== exp)
            abort_run($sformatf("Error at %0t: %s was %h, expected %h", $time, what, got, exp));
    endtask

    function automatic word_t mem_pattern(input addr_t a);
        return a ^ 32'h5a5a_0000;
    endfunction

    function automatic word_t apply_strobe(input word_t old_w, input word_t new_w,
                                           input strb_t s);
        word_t mask;
        mask = {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    // drives one processor request and counts cycles up to completion in lat
    task automatic access(input logic we, input addr_t addr, input word_t wd, input strb_t st,
                          output word_t rd, output int lat);
        @(posedge clk);
        d_req   <= 1'b1;
        d_we    <= we;
        d_addr  <= addr;
        d_wdata <= wd;
        d_wstrb <= st;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (d_stall);
        rd = d_rdata;
        @(posedge clk);
        d_req <= 1'b0;
    endtask

    task automatic cold_read_miss(input addr_t base);
        word_t rd;
        int    lat;
        int    ar_before;
        ar_before = ar_count;
        access(1'b0, base + 32'h24, '0, '0, rd, lat);
        check_word("cold read miss", rd, mem_pattern(base + 32'h24));
        if (ar_count != ar_before + 1)
            abort_run("read miss did not issue exactly one refill burst");
        check_addr("refill araddr", last_araddr, base);
    endtask

    task automatic same_line_read(input addr_t base);
        word_t rd;
        int    lat;
        int    arv_before;
        arv_before = arvalid_cycles;
        access(1'b0, base + 32'h3c, '0, '0, rd, lat);
        check_word("read hit", rd, mem_pattern(base + 32'h3c));
        if (arvalid_cycles != arv_before)
            abort_run("arvalid went high during a read hit");
        if (lat != 2)
            abort_run("read hit did not complete in 2 cycles");
    endtask

    task automatic partial_write_hit(input addr_t base);
        word_t rd;
        int    lat;
        access(1'b1, base + 32'h24, HIT_DATA, HIT_STRB, rd, lat);
        if (lat != 2)
            abort_run("write hit did not complete in 2 cycles");
        access(1'b0, base + 32'h24, '0, '0, rd, lat);
        check_word("read after write hit", rd,
                   apply_strobe(mem_pattern(base + 32'h24), HIT_DATA, HIT_STRB));
    endtask

    task automatic write_miss_merge(input addr_t base);
        word_t rd;
        int    lat;
        access(1'b1, base + 32'h88, MISS_DATA, MISS_STRB, rd, lat);
        check_addr("write miss araddr", last_araddr, base + 32'h80);
        access(1'b0, base + 32'h88, '0, '0, rd, lat);
        check_word("read after write miss", rd,
                   apply_strobe(mem_pattern(base + 32'h88), MISS_DATA, MISS_STRB));
    endtask

    // same index with the next tag evicts the line dirtied by the write hit
    task automatic dirty_eviction(input addr_t base);
        word_t rd;
        int    lat;
        int    aw_before;
        word_t dirty_word;
        dirty_word = apply_strobe(mem_pattern(base + 32'h24), HIT_DATA, HIT_STRB);
        aw_before = aw_count;
        access(1'b0, base + 32'h1024, '0, '0, rd, lat);
        check_word("read of conflicting tag", rd, mem_pattern(base + 32'h1024));
        if (aw_count != aw_before + 1)
            abort_run("dirty victim line was not written back");
        check_addr("write-back awaddr", last_awaddr, base);
        check_addr("refill araddr after write-back", last_araddr, base + 32'h1000);
        check_word("written-back dirty word", i_mem_model.mem[base + 32'h24], dirty_word);
        check_word("written-back clean word", i_mem_model.mem[base + 32'h3c],
                   mem_pattern(base + 32'h3c));
        access(1'b0, base + 32'h24, '0, '0, rd, lat);
        check_word("reread of evicted line", rd, dirty_word);
        if (aw_count != aw_before + 1)
            abort_run("clean line was written back");
    endtask

    task automatic run_pass(input logic stalls, input addr_t base);
        resetn   <= 1'b0;
        stall_en <= stalls;
        repeat (4) @(posedge clk);
        resetn <= 1'b1;
        cold_read_miss(base);
        same_line_read(base);
        partial_write_hit(base);
        write_miss_merge(base);
        dirty_eviction(base);
    endtask

    initial begin
        resetn   = 1'b0;
        stall_en = 1'b0;
        d_req    = 1'b0;
        d_we     = 1'b0;
        d_addr   = '0;
        d_wdata  = '0;
        d_wstrb  = '0;
        run_pass(1'b0, 32'h0001_0000);
        // fresh region so the second pass sees untouched memory
        run_pass(1'b1, 32'h0020_0000);
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+include
verilog/dcache_pkg.sv
verilog/dcache_store.sv
verilog/dcache_lookup.sv
verilog/dcache_ctrl.sv
verilog/dcache_line_buf.sv
verilog/dcache_top.sv
test/tb_mem_model.sv
test/tb_dcache.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_dcache \
    -Mdir obj_dir -o tb_dcache

./obj_dir/tb_dcache > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
